// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_load_cluster
FILELIST  = load_cluster_top.f
OBJ_DIR   = obj_dir
PASS_MSG  = ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list the targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// ==== load_cluster_top.f ====
source/lsu_pkg.sv
source/load_dispatch.sv
source/load_lane.sv
source/data_bank_array.sv
source/result_arbiter.sv
source/load_cluster_top.sv
tests/tb_load_cluster.sv

// ==== source/data_bank_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_bank_array
    import lsu_pkg::*;
#(
    parameter int NUM_LANES = 2,
    parameter int MEM_WORDS = 256,
    localparam int BANK_WORDS = MEM_WORDS / NUM_BANKS,
    localparam int ROW_W = row_bits(MEM_WORDS)
) (
    input  logic                             clk,
    input  logic [NUM_LANES-1:0]             i_rd_req,
    input  logic [NUM_LANES-1:0][BANK_W-1:0] i_rd_bank,
    input  logic [NUM_LANES-1:0][ROW_W-1:0]  i_rd_row,
    output logic [NUM_LANES-1:0]             o_rd_conflict,
    output word_t [NUM_LANES-1:0]            o_rd_data,
    input  logic                             i_wr_en,
    input  word_t                            i_wr_addr,
    input  logic [WORD_BYTES-1:0]            i_wr_strb,
    input  word_t                            i_wr_data
);

    word_t mem [NUM_BANKS][BANK_WORDS];

    logic [BANK_W-1:0] wr_bank;
    logic [ROW_W-1:0]  wr_row;

    assign wr_bank = i_wr_addr[OFF_W +: BANK_W];
    assign wr_row  = i_wr_addr[OFF_W+BANK_W +: ROW_W];

    // byte strobed write
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (i_wr_strb[b]) begin
                    mem[wr_bank][wr_row][b*8 +: 8] <= i_wr_data[b*8 +: 8];
                end
            end
        end
    end

    // the write owns its bank this cycle
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            o_rd_conflict[l] = i_rd_req[l] && i_wr_en && (i_rd_bank[l] == wr_bank);
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (i_rd_req[l] && !o_rd_conflict[l]) begin
                o_rd_data[l] <= mem[i_rd_bank[l]][i_rd_row[l]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/load_cluster_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_cluster_top
    import lsu_pkg::*;
#(
    parameter int NUM_LANES      = 2,
    parameter int MEM_WORDS      = 256,
    parameter int RES_FIFO_DEPTH = 4,
    localparam int ROW_W = row_bits(MEM_WORDS)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_ld_valid,
    output logic                  o_ld_ready,
    input  load_op_t              i_ld_op,
    input  ld_tag_t               i_ld_tag,
    input  word_t                 i_ld_base,
    input  word_t                 i_ld_offset,
    output logic                  o_res_valid,
    input  logic                  i_res_ready,
    output ld_tag_t               o_res_tag,
    output ld_status_t            o_res_status,
    output word_t                 o_res_data,
    input  logic                  i_wr_en,
    input  word_t                 i_wr_addr,
    input  word_t                 i_wr_data,
    input  logic [WORD_BYTES-1:0] i_wr_strb
);

    logic [NUM_LANES-1:0]             lane_space, issue;
    load_op_t                         issue_op;
    ld_tag_t                          issue_tag;
    word_t                            issue_base, issue_offset;
    logic [NUM_LANES-1:0]             rd_req, rd_conflict;
    logic [NUM_LANES-1:0][BANK_W-1:0] rd_bank;
    logic [NUM_LANES-1:0][ROW_W-1:0]  rd_row;
    word_t [NUM_LANES-1:0]            rd_data;
    logic [NUM_LANES-1:0]             lane_valid;
    ld_tag_t [NUM_LANES-1:0]          lane_tag;
    ld_status_t [NUM_LANES-1:0]       lane_status;
    word_t [NUM_LANES-1:0]            lane_data;

    load_dispatch #(
        .NUM_LANES(NUM_LANES)
    ) u_dispatch (
        .clk            (clk),
        .rst            (rst),
        .i_ld_valid     (i_ld_valid),
        .i_ld_op        (i_ld_op),
        .i_ld_tag       (i_ld_tag),
        .i_ld_base      (i_ld_base),
        .i_ld_offset    (i_ld_offset),
        .o_ld_ready     (o_ld_ready),
        .i_lane_space   (lane_space),
        .o_issue        (issue),
        .o_issue_op     (issue_op),
        .o_issue_tag    (issue_tag),
        .o_issue_base   (issue_base),
        .o_issue_offset (issue_offset)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        load_lane #(
            .MEM_WORDS(MEM_WORDS)
        ) u_lane (
            .clk           (clk),
            .rst           (rst),
            .i_issue       (issue[g]),
            .i_op          (issue_op),
            .i_tag         (issue_tag),
            .i_base        (issue_base),
            .i_offset      (issue_offset),
            .o_rd_req      (rd_req[g]),
            .o_rd_bank     (rd_bank[g]),
            .o_rd_row      (rd_row[g]),
            .i_rd_conflict (rd_conflict[g]),
            .i_rd_data     (rd_data[g]),
            .o_res_valid   (lane_valid[g]),
            .o_res_tag     (lane_tag[g]),
            .o_res_status  (lane_status[g]),
            .o_res_data    (lane_data[g])
        );
    end

    data_bank_array #(
        .NUM_LANES(NUM_LANES),
        .MEM_WORDS(MEM_WORDS)
    ) u_banks (
        .clk           (clk),
        .i_rd_req      (rd_req),
        .i_rd_bank     (rd_bank),
        .i_rd_row      (rd_row),
        .o_rd_conflict (rd_conflict),
        .o_rd_data     (rd_data),
        .i_wr_en       (i_wr_en),
        .i_wr_addr     (i_wr_addr),
        .i_wr_strb     (i_wr_strb),
        .i_wr_data     (i_wr_data)
    );

    // issue pulse doubles as the slot reservation
    result_arbiter #(
        .NUM_LANES      (NUM_LANES),
        .RES_FIFO_DEPTH (RES_FIFO_DEPTH)
    ) u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .i_reserve     (issue),
        .o_lane_space  (lane_space),
        .i_lane_valid  (lane_valid),
        .i_lane_tag    (lane_tag),
        .i_lane_status (lane_status),
        .i_lane_data   (lane_data),
        .o_res_valid   (o_res_valid),
        .i_res_ready   (i_res_ready),
        .o_res_tag     (o_res_tag),
        .o_res_status  (o_res_status),
        .o_res_data    (o_res_data)
    );

endmodule

`default_nettype wire

// ==== source/load_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_dispatch
    import lsu_pkg::*;
#(
    parameter int NUM_LANES = 2,
    localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_ld_valid,
    input  load_op_t             i_ld_op,
    input  ld_tag_t              i_ld_tag,
    input  word_t                i_ld_base,
    input  word_t                i_ld_offset,
    output logic                 o_ld_ready,
    input  logic [NUM_LANES-1:0] i_lane_space,
    output logic [NUM_LANES-1:0] o_issue,
    output load_op_t             o_issue_op,
    output ld_tag_t              o_issue_tag,
    output word_t                o_issue_base,
    output word_t                o_issue_offset
);

    logic [LW-1:0] rr_ptr;
    logic          accept;

    // a full lane stalls the input, it is not skipped
    assign o_ld_ready = i_lane_space[rr_ptr];
    assign accept     = i_ld_valid && o_ld_ready;
    assign o_issue    = accept ? (NUM_LANES'(1) << rr_ptr) : '0;

    // only the lane with its issue bit set captures these
    assign o_issue_op     = i_ld_op;
    assign o_issue_tag    = i_ld_tag;
    assign o_issue_base   = i_ld_base;
    assign o_issue_offset = i_ld_offset;

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (accept) begin
            rr_ptr <= (rr_ptr == LW'(NUM_LANES - 1)) ? '0 : rr_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/load_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_lane
    import lsu_pkg::*;
#(
    parameter int MEM_WORDS = 256,
    localparam int ROW_W = row_bits(MEM_WORDS)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_issue,
    input  load_op_t          i_op,
    input  ld_tag_t           i_tag,
    input  word_t             i_base,
    input  word_t             i_offset,
    output logic              o_rd_req,
    output logic [BANK_W-1:0] o_rd_bank,
    output logic [ROW_W-1:0]  o_rd_row,
    input  logic              i_rd_conflict,
    input  word_t             i_rd_data,
    output logic              o_res_valid,
    output ld_tag_t           o_res_tag,
    output ld_status_t        o_res_status,
    output word_t             o_res_data
);

    localparam word_t MEM_BYTES = word_t'(MEM_WORDS) * WORD_BYTES;

    logic                  s0_vld, s1_vld, s2_vld, s3_vld;
    load_op_t              s0_op, s1_op, s2_op;
    ld_tag_t               s0_tag, s1_tag, s2_tag, s3_tag;
    word_t                 s0_base, s0_offset, s0_addr, s1_addr;
    logic [3:0]            s0_size;
    logic [WORD_BYTES-1:0] s0_len_bytes, s0_byte_mask, s1_byte_mask, s2_byte_mask;
    logic                  s0_misaligned, s1_misaligned, s1_in_range;
    ld_status_t            s1_status, s2_status, s3_status;
    logic [OFF_W-1:0]      s2_off;
    word_t                 s2_bit_mask, s2_shifted, s2_ext, s3_data;

    // s0: address, size, byte mask
    always_ff @(posedge clk) begin
        if (i_issue) begin
            s0_op     <= i_op;
            s0_tag    <= i_tag;
            s0_base   <= i_base;
            s0_offset <= i_offset;
        end
    end

    assign s0_addr = s0_base + s0_offset;

    always_comb begin
        case (s0_op)
            LB, LBU: begin
                s0_size      = 4'd1;
                s0_len_bytes = 8'h01;
            end
            LH, LHU: begin
                s0_size      = 4'd2;
                s0_len_bytes = 8'h03;
            end
            LW, LWU: begin
                s0_size      = 4'd4;
                s0_len_bytes = 8'h0f;
            end
            default: begin
                s0_size      = 4'd8;
                s0_len_bytes = 8'hff;
            end
        endcase
    end

    assign s0_byte_mask  = s0_len_bytes << s0_addr[OFF_W-1:0];
    assign s0_misaligned = (s0_addr[OFF_W-1:0] & OFF_W'(s0_size - 4'd1)) != '0;

    // s1: range check, bank request, status
    always_ff @(posedge clk) begin
        s1_op         <= s0_op;
        s1_tag        <= s0_tag;
        s1_addr       <= s0_addr;
        s1_byte_mask  <= s0_byte_mask;
        s1_misaligned <= s0_misaligned;
    end

    assign s1_in_range = s1_addr < MEM_BYTES;
    // faulting loads never reach the banks
    assign o_rd_req    = s1_vld && !s1_misaligned && s1_in_range;
    assign o_rd_bank   = s1_addr[OFF_W +: BANK_W];
    assign o_rd_row    = s1_addr[OFF_W+BANK_W +: ROW_W];

    always_comb begin
        if (s1_misaligned) begin
            s1_status = LD_MISALIGNED;
        end else if (!s1_in_range) begin
            s1_status = LD_ACCESS_FAULT;
        end else if (i_rd_conflict) begin
            s1_status = LD_REPLAY;
        end else begin
            s1_status = LD_OK;
        end
    end

    // s2: byte select and extension
    always_ff @(posedge clk) begin
        s2_op        <= s1_op;
        s2_tag       <= s1_tag;
        s2_status    <= s1_status;
        s2_off       <= s1_addr[OFF_W-1:0];
        s2_byte_mask <= s1_byte_mask;
    end

    always_comb begin
        for (int b = 0; b < WORD_BYTES; b++) begin
            s2_bit_mask[b*8 +: 8] = {8{s2_byte_mask[b]}};
        end
    end

    // masked bytes shift down already zero extended
    assign s2_shifted = (i_rd_data & s2_bit_mask) >> {s2_off, 3'b000};

    always_comb begin
        case (s2_op)
            LB:      s2_ext = {{56{s2_shifted[7]}}, s2_shifted[7:0]};
            LH:      s2_ext = {{48{s2_shifted[15]}}, s2_shifted[15:0]};
            LW:      s2_ext = {{32{s2_shifted[31]}}, s2_shifted[31:0]};
            default: s2_ext = s2_shifted;
        endcase
    end

    // s3: result record
    always_ff @(posedge clk) begin
        s3_tag    <= s2_tag;
        s3_status <= s2_status;
        s3_data   <= (s2_status == LD_OK) ? s2_ext : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s0_vld <= 1'b0;
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
            s3_vld <= 1'b0;
        end else begin
            s0_vld <= i_issue;
            s1_vld <= s0_vld;
            s2_vld <= s1_vld;
            s3_vld <= s2_vld;
        end
    end

    assign o_res_valid  = s3_vld;
    assign o_res_tag    = s3_tag;
    assign o_res_status = s3_status;
    assign o_res_data   = s3_data;

endmodule

`default_nettype wire

// ==== source/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    localparam int XLEN       = 64;
    localparam int WORD_BYTES = XLEN / 8;
    localparam int OFF_W      = $clog2(WORD_BYTES);
    localparam int NUM_BANKS  = 8;
    localparam int BANK_W     = $clog2(NUM_BANKS);

    typedef logic [XLEN-1:0] word_t;
    typedef logic [7:0] ld_tag_t;

    typedef enum logic [2:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        LWU,
        LD
    } load_op_t;

    typedef enum logic [1:0] {
        LD_OK,
        LD_REPLAY,
        LD_MISALIGNED,
        LD_ACCESS_FAULT
    } ld_status_t;

    // row index width inside one bank
    function automatic int row_bits(int mem_words);
        return $clog2(mem_words / NUM_BANKS);
    endfunction

endpackage

`default_nettype wire

// ==== source/result_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_arbiter
    import lsu_pkg::*;
#(
    parameter int NUM_LANES      = 2,
    parameter int RES_FIFO_DEPTH = 4,
    localparam int AW = (RES_FIFO_DEPTH > 1) ? $clog2(RES_FIFO_DEPTH) : 1,
    localparam int CW = $clog2(RES_FIFO_DEPTH + 1),
    localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [NUM_LANES-1:0]        i_reserve,
    output logic [NUM_LANES-1:0]        o_lane_space,
    input  logic [NUM_LANES-1:0]        i_lane_valid,
    input  ld_tag_t [NUM_LANES-1:0]     i_lane_tag,
    input  ld_status_t [NUM_LANES-1:0]  i_lane_status,
    input  word_t [NUM_LANES-1:0]       i_lane_data,
    output logic                        o_res_valid,
    input  logic                        i_res_ready,
    output ld_tag_t                     o_res_tag,
    output ld_status_t                  o_res_status,
    output word_t                       o_res_data
);

    ld_tag_t    tag_mem    [NUM_LANES][RES_FIFO_DEPTH];
    ld_status_t status_mem [NUM_LANES][RES_FIFO_DEPTH];
    word_t      data_mem   [NUM_LANES][RES_FIFO_DEPTH];

    logic [AW-1:0]        wr_ptr   [NUM_LANES];
    logic [AW-1:0]        rd_ptr   [NUM_LANES];
    logic [CW-1:0]        fill_cnt [NUM_LANES];
    logic [CW-1:0]        resv_cnt [NUM_LANES];
    logic [LW-1:0]        rr_ptr, sel;
    logic [NUM_LANES-1:0] pop;

    function automatic logic [AW-1:0] ptr_inc(logic [AW-1:0] ptr);
        return (ptr == AW'(RES_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (i_lane_valid[l]) begin
                tag_mem[l][wr_ptr[l]]    <= i_lane_tag[l];
                status_mem[l][wr_ptr[l]] <= i_lane_status[l];
                data_mem[l][wr_ptr[l]]   <= i_lane_data[l];
            end
        end
    end

    // reservation count covers records still in the lane pipeline
    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (rst) begin
                wr_ptr[l]   <= '0;
                rd_ptr[l]   <= '0;
                fill_cnt[l] <= '0;
                resv_cnt[l] <= '0;
            end else begin
                if (i_lane_valid[l]) begin
                    wr_ptr[l] <= ptr_inc(wr_ptr[l]);
                end
                if (pop[l]) begin
                    rd_ptr[l] <= ptr_inc(rd_ptr[l]);
                end
                fill_cnt[l] <= fill_cnt[l] + CW'(i_lane_valid[l]) - CW'(pop[l]);
                resv_cnt[l] <= resv_cnt[l] + CW'(i_reserve[l]) - CW'(pop[l]);
            end
        end
    end

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            o_lane_space[l] = resv_cnt[l] < CW'(RES_FIFO_DEPTH);
        end
    end

    // first non-empty fifo at or after the pointer
    always_comb begin
        int idx;
        o_res_valid = 1'b0;
        sel         = rr_ptr;
        for (int i = 0; i < NUM_LANES; i++) begin
            idx = int'(rr_ptr) + i;
            if (idx >= NUM_LANES) begin
                idx = idx - NUM_LANES;
            end
            if (!o_res_valid && fill_cnt[idx] != '0) begin
                o_res_valid = 1'b1;
                sel         = LW'(idx);
            end
        end
    end

    assign pop          = (o_res_valid && i_res_ready) ? (NUM_LANES'(1) << sel) : '0;
    assign o_res_tag    = tag_mem[sel][rd_ptr[sel]];
    assign o_res_status = status_mem[sel][rd_ptr[sel]];
    assign o_res_data   = data_mem[sel][rd_ptr[sel]];

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (o_res_valid && i_res_ready) begin
            rr_ptr <= (sel == LW'(NUM_LANES - 1)) ? '0 : sel + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_load_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_load_cluster
    import lsu_pkg::*;
();

    localparam int NUM_LANES      = 2;
    localparam int MEM_WORDS      = 256;
    localparam int RES_FIFO_DEPTH = 4;
    localparam int MEM_BYTES      = MEM_WORDS * 8;
    localparam int TIMEOUT        = 200;
    localparam logic [2:0] HAMMER_BANK = 3'd3;
    localparam word_t HAMMER_ADDR      = 64'd24;

    logic       clk;
    logic       rst;
    logic       i_ld_valid;
    logic       o_ld_ready;
    load_op_t   i_ld_op;
    ld_tag_t    i_ld_tag;
    word_t      i_ld_base;
    word_t      i_ld_offset;
    logic       o_res_valid;
    logic       i_res_ready;
    ld_tag_t    o_res_tag;
    ld_status_t o_res_status;
    word_t      o_res_data;
    logic       i_wr_en;
    word_t      i_wr_addr;
    word_t      i_wr_data;
    logic [7:0] i_wr_strb;

    integer     seed;
    int         value_errors;
    int         other_errors;
    int         n_pending;
    int         n_accepted;
    bit         saw_block;
    logic [7:0] ref_mem [MEM_BYTES];
    ld_status_t exp_status [256];
    word_t      exp_data [256];
    bit         pending [256];
    ld_tag_t    got_tag [$];
    ld_status_t got_status [$];
    word_t      got_data [$];
    load_op_t   lq_op [$];
    ld_tag_t    lq_tag [$];
    word_t      lq_base [$];
    word_t      lq_off [$];

    load_cluster_top #(
        .NUM_LANES      (NUM_LANES),
        .MEM_WORDS      (MEM_WORDS),
        .RES_FIFO_DEPTH (RES_FIFO_DEPTH)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .i_ld_valid   (i_ld_valid),
        .o_ld_ready   (o_ld_ready),
        .i_ld_op      (i_ld_op),
        .i_ld_tag     (i_ld_tag),
        .i_ld_base    (i_ld_base),
        .i_ld_offset  (i_ld_offset),
        .o_res_valid  (o_res_valid),
        .i_res_ready  (i_res_ready),
        .o_res_tag    (o_res_tag),
        .o_res_status (o_res_status),
        .o_res_data   (o_res_data),
        .i_wr_en      (i_wr_en),
        .i_wr_addr    (i_wr_addr),
        .i_wr_data    (i_wr_data),
        .i_wr_strb    (i_wr_strb)
    );

    always #4 clk = ~clk;

    // result monitor, samples mid cycle while inputs are steady
    always @(negedge clk) begin
        #2;
        if (!rst && o_res_valid === 1'b1 && i_res_ready === 1'b1) begin
            got_tag.push_back(o_res_tag);
            got_status.push_back(o_res_status);
            got_data.push_back(o_res_data);
        end
    end

    task automatic check_status(input string name, input ld_status_t got, input ld_status_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR t=%0t %s: got %s, expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_data(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input ld_tag_t got, input ld_tag_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR t=%0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            value_errors++;
            $display("ERROR t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic int op_size(input load_op_t op);
        case (op)
            LB, LBU: return 1;
            LH, LHU: return 2;
            LW, LWU: return 4;
            default: return 8;
        endcase
    endfunction

    function automatic word_t ref_word(input word_t addr);
        word_t w;
        for (int b = 0; b < 8; b++) begin
            w[b*8 +: 8] = ref_mem[int'(addr) + b];
        end
        return w;
    endfunction

    // fill value mixes every address bit
    function automatic logic [7:0] pattern_byte(input int a);
        return 8'(a * 37) ^ 8'(a >> 5) ^ 8'h96;
    endfunction

    task automatic write_word(input word_t addr, input word_t data, input logic [7:0] strb);
        i_wr_en   = 1'b1;
        i_wr_addr = addr;
        i_wr_data = data;
        i_wr_strb = strb;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                ref_mem[int'(addr) + b] = data[b*8 +: 8];
            end
        end
        @(negedge clk);
    endtask

    task automatic preload_memory;
        word_t       w;
        logic [31:0] r;
        logic [31:0] lo;
        for (int a = 0; a < MEM_WORDS; a++) begin
            for (int b = 0; b < 8; b++) begin
                w[b*8 +: 8] = pattern_byte(a * 8 + b);
            end
            write_word(word_t'(a) * 8, w, 8'hff);
        end
        // partial strobes on top of the fill
        for (int i = 0; i < 40; i++) begin
            r  = $random(seed);
            lo = $random(seed);
            write_word(word_t'(r[7:0]) * 8, {r, lo}, r[15:8]);
        end
        i_wr_en = 1'b0;
    endtask

    task automatic drive_ready(input int mode);
        logic [31:0] r;
        if (mode == 2) begin
            r = $random(seed);
            i_res_ready = r[0];
        end else begin
            i_res_ready = (mode == 1);
        end
    endtask

    task automatic drive_hammer;
        i_wr_en   = 1'b1;
        i_wr_addr = HAMMER_ADDR;
        i_wr_data = ref_word(HAMMER_ADDR);
        i_wr_strb = 8'hff;
    endtask

    task automatic queue_load(input load_op_t op, input ld_tag_t tag, input word_t addr);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        lq_op.push_back(op);
        lq_tag.push_back(tag);
        lq_base.push_back({hi, lo});
        lq_off.push_back(addr - {hi, lo});
    endtask

    task automatic queue_random_load(input ld_tag_t tag, input bit allow_bad);
        logic [31:0] r;
        load_op_t    op;
        word_t       addr;
        r    = $random(seed);
        op   = load_op_t'(3'(r[31:16] % 7));
        addr = allow_bad ? word_t'(r[11:0]) : word_t'(r[10:0]);
        if (!allow_bad || r[13:12] != 2'b00) begin
            addr = addr & ~(word_t'(op_size(op)) - 1);
        end
        queue_load(op, tag, addr);
    endtask

    // expected record straight from the address rules
    task automatic expect_load(input load_op_t op, input ld_tag_t tag, input word_t addr,
                               input bit hammer);
        int         size;
        ld_status_t st;
        word_t      data;
        size = op_size(op);
        data = '0;
        if (addr % word_t'(size) != 0) begin
            st = LD_MISALIGNED;
        end else if (addr >= word_t'(MEM_BYTES)) begin
            st = LD_ACCESS_FAULT;
        end else if (hammer && addr[5:3] == HAMMER_BANK) begin
            st = LD_REPLAY;
        end else begin
            st = LD_OK;
            for (int b = 0; b < size; b++) begin
                data[b*8 +: 8] = ref_mem[int'(addr) + b];
            end
            if ((op == LB || op == LH || op == LW) && data[size*8-1]) begin
                for (int b = size * 8; b < XLEN; b++) begin
                    data[b] = 1'b1;
                end
            end
        end
        if (pending[tag]) begin
            other_errors++;
            $display("tag %0d was reused while still in flight", tag);
        end
        exp_status[tag] = st;
        exp_data[tag]   = data;
        pending[tag]    = 1'b1;
        n_pending++;
    endtask

    // offers queued loads one per cycle, holding each until accepted
    task automatic run_loads(input bit hammer, input int ready_mode, input bit stop_blocked);
        int idle;
        int stall;
        bit took;
        idle  = 0;
        stall = 0;
        while (lq_op.size() > 0) begin
            if (stop_blocked && stall >= 8) begin
                break;
            end
            drive_ready(ready_mode);
            if (hammer) begin
                drive_hammer();
            end
            i_ld_valid  = 1'b1;
            i_ld_op     = lq_op[0];
            i_ld_tag    = lq_tag[0];
            i_ld_base   = lq_base[0];
            i_ld_offset = lq_off[0];
            #2;
            took = (o_ld_ready === 1'b1);
            if (took) begin
                stall = 0;
            end else begin
                stall++;
                saw_block = 1'b1;
            end
            @(negedge clk);
            if (took) begin
                expect_load(lq_op[0], lq_tag[0], lq_base[0] + lq_off[0], hammer);
                void'(lq_op.pop_front());
                void'(lq_tag.pop_front());
                void'(lq_base.pop_front());
                void'(lq_off.pop_front());
                n_accepted++;
                idle = 0;
            end else begin
                idle++;
                if (!stop_blocked && idle >= TIMEOUT) begin
                    other_errors++;
                    $display("timeout: o_ld_ready stayed low for %0d cycles", TIMEOUT);
                    lq_op.delete();
                    lq_tag.delete();
                    lq_base.delete();
                    lq_off.delete();
                    break;
                end
            end
        end
        i_ld_valid = 1'b0;
        if (hammer) begin
            // keep the bank busy while the last loads pass s1
            repeat (4) begin
                drive_hammer();
                @(negedge clk);
            end
            i_wr_en = 1'b0;
        end
    endtask

    task automatic wait_results(input int n);
        int waited;
        waited = 0;
        while (got_tag.size() < n && waited < TIMEOUT) begin
            i_res_ready = 1'b1;
            @(negedge clk);
            waited++;
        end
        if (got_tag.size() < n) begin
            other_errors++;
            $display("timeout: only %0d of %0d results arrived", got_tag.size(), n);
        end
        // extra cycles so a duplicate record shows up too
        repeat (8) @(negedge clk);
    endtask

    task automatic match_records;
        ld_tag_t    t;
        ld_status_t s;
        word_t      d;
        while (got_tag.size() > 0) begin
            t = got_tag.pop_front();
            s = got_status.pop_front();
            d = got_data.pop_front();
            if (!pending[t]) begin
                other_errors++;
                $display("record for tag %0d was not expected or came twice", t);
            end else begin
                check_status($sformatf("o_res_status tag %0d", t), s, exp_status[t]);
                check_data($sformatf("o_res_data tag %0d", t), d, exp_data[t]);
                pending[t] = 1'b0;
            end
        end
        for (int i = 0; i < 256; i++) begin
            if (pending[i]) begin
                other_errors++;
                $display("no record arrived for tag %0d", i);
                pending[i] = 1'b0;
            end
        end
        n_pending = 0;
    endtask

    task automatic test_every_op_offset;
        int       words [4];
        int       size;
        load_op_t op;
        ld_tag_t  tag;
        words = '{0, 37, 130, MEM_WORDS - 1};
        tag   = '0;
        foreach (words[w]) begin
            for (int k = 0; k < 7; k++) begin
                op   = load_op_t'(3'(k));
                size = op_size(op);
                for (int off = 0; off < 8; off += size) begin
                    tag++;
                    queue_load(op, tag, word_t'(words[w]) * 8 + word_t'(off));
                    run_loads(1'b0, 1, 1'b0);
                    wait_results(1);
                    if (got_tag.size() > 0) begin
                        check_tag("o_res_tag", got_tag[0], tag);
                    end
                    match_records();
                end
            end
        end
    endtask

    task automatic test_misaligned_and_fault;
        load_op_t ops [13];
        word_t    addrs [13];
        ops   = '{LH, LW, LD, LW, LHU, LB, LD, LW, LD, LH, LD, LW, LD};
        addrs = '{64'd1, 64'd2, 64'd4, 64'd6, 64'h103, 64'd2048, 64'd2056,
                  64'h1_0000_0000, 64'hffff_ffff_ffff_fff8, 64'd2049, 64'h4004,
                  64'hffff_ffff_ffff_fffe, 64'd2040};
        foreach (ops[i]) begin
            queue_load(ops[i], ld_tag_t'(i), addrs[i]);
        end
        run_loads(1'b0, 1, 1'b0);
        wait_results(n_pending);
        match_records();
    endtask

    task automatic test_bank_conflict;
        logic [31:0] r;
        load_op_t    op;
        word_t       addr;
        for (int i = 0; i < 16; i++) begin
            r    = $random(seed);
            op   = load_op_t'(3'(r[31:16] % 7));
            // even loads hit bank 3, odd loads bank 4
            addr = word_t'(r[4:0]) * 64 + ((i % 2 == 0) ? 64'd24 : 64'd32) + word_t'(r[10:8]);
            addr = addr & ~(word_t'(op_size(op)) - 1);
            queue_load(op, ld_tag_t'(i), addr);
        end
        run_loads(1'b1, 1, 1'b0);
        wait_results(n_pending);
        match_records();
    endtask

    task automatic test_back_pressure;
        saw_block  = 1'b0;
        n_accepted = 0;
        for (int i = 0; i < NUM_LANES * RES_FIFO_DEPTH + 6; i++) begin
            queue_random_load(ld_tag_t'(i), 1'b0);
        end
        run_loads(1'b0, 0, 1'b1);
        if (!saw_block) begin
            other_errors++;
            $display("o_ld_ready never fell while i_res_ready was held low");
        end
        check_count("accepted loads", n_accepted, NUM_LANES * RES_FIFO_DEPTH);
        run_loads(1'b0, 1, 1'b0);
        wait_results(n_pending);
        match_records();
    endtask

    task automatic test_random_mix;
        for (int i = 0; i < 200; i++) begin
            queue_random_load(ld_tag_t'(i), 1'b1);
        end
        run_loads(1'b0, 2, 1'b0);
        wait_results(n_pending);
        match_records();
    endtask

    initial begin
        seed         = 32'ha001_20a3;
        clk          = 1'b0;
        rst          = 1'b1;
        i_ld_valid   = 1'b0;
        i_ld_op      = LB;
        i_ld_tag     = '0;
        i_ld_base    = '0;
        i_ld_offset  = '0;
        i_res_ready  = 1'b0;
        i_wr_en      = 1'b0;
        i_wr_addr    = '0;
        i_wr_data    = '0;
        i_wr_strb    = '0;
        value_errors = 0;
        other_errors = 0;
        n_pending    = 0;
        n_accepted   = 0;
        saw_block    = 1'b0;
        for (int i = 0; i < 256; i++) begin
            pending[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #2;
        check_flag("o_ld_ready", o_ld_ready, 1'b1);
        check_flag("o_res_valid", o_res_valid, 1'b0);
        @(negedge clk);

        preload_memory();
        test_every_op_offset();
        test_misaligned_and_fault();
        test_bank_conflict();
        test_back_pressure();
        test_random_mix();

        $display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
